//--- verilog.f
cpuPkg.sv
immediateDecoder.sv
registerFile.sv
offsetAlu.sv
apbControl.sv
ldiDatapath.sv
ldiDatapath_assertions.sv
ldiDatapath_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module ldiDatapath_tb -f verilog.f -o simv
	-./obj_dir/simv > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- ldiDatapath_tb.sv
// Testbench for the immediate-group slice: clock, reset, APB tasks, compare tasks, tests, timeout
module ldiDatapath_tb;

   timeunit 1ns;
   timeprecision 10ps;

   localparam int ClockPeriod = 8;
   localparam int SampleDelay = 2;
   localparam int ResetCycles = 8;
   localparam int TimeoutCycles = 2000;
   localparam int LogicRounds = 6;

   logic          Clock;
   logic          rst;
   logic          pSel;
   logic          pEnable;
   logic          pWrite;
   cpuPkg::paddrT pAddr;
   cpuPkg::wordT  pWData;
   cpuPkg::wordT  pRData;
   logic          pReady;
   logic          pSlvErr;

   integer        seed = 32'h3f309d14;
   int            cycleCount = 0;
   // Expected contents of the sixteen general registers
   cpuPkg::wordT  model [cpuPkg::RegCount];

   ldiDatapath dut (
      .Clock(Clock), .rst(rst), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
      .pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr)
   );

   initial begin
      Clock = 1'b0;
      forever #(ClockPeriod / 2) Clock = ~Clock;
   end

   // Run limit, about four times the length of all tests
   initial begin
      while (cycleCount < TimeoutCycles) begin
         @(posedge Clock);
         cycleCount++;
      end
      $display("Timeout: the tests did not finish within %0d clock cycles", TimeoutCycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped by timeout");
   end

   task automatic failRun();
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkWord(input string name, input cpuPkg::wordT expected,
                            input cpuPkg::wordT actual);
      if (actual !== expected) begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         failRun();
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         failRun();
      end
   endtask

   task automatic checkCount(input string name, input int expected, input int actual);
      if (actual != expected) begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         failRun();
      end
   endtask

   // Instruction word: opcode, Ra, Rb, 19-bit constant
   function automatic cpuPkg::wordT encodeInstr(input cpuPkg::opcodeT op,
                                                input cpuPkg::regIdxT ra,
                                                input cpuPkg::regIdxT rb,
                                                input logic [18:0] c);
      return {op, ra, rb, c};
   endfunction

   function automatic cpuPkg::wordT signExtend(input logic [18:0] c);
      return {{13{c[18]}}, c};
   endfunction

   function automatic cpuPkg::paddrT regAddr(input cpuPkg::regIdxT idx);
      return cpuPkg::AddrRegBase + {2'b00, idx, 2'b00};
   endfunction

   // Setup phase, then access phase held until pReady
   task automatic apbTransfer(input logic write, input cpuPkg::paddrT addr,
                              input cpuPkg::wordT wdata, output cpuPkg::wordT rdata,
                              output int waits, output logic err);
      @(negedge Clock);
      pSel = 1'b1;
      pEnable = 1'b0;
      pWrite = write;
      pAddr = addr;
      pWData = wdata;
      @(negedge Clock);
      pEnable = 1'b1;
      waits = 0;
      #SampleDelay;
      while (!pReady) begin
         waits++;
         @(negedge Clock);
         #SampleDelay;
      end
      rdata = pRData;
      err = pSlvErr;
      @(negedge Clock);
      pSel = 1'b0;
      pEnable = 1'b0;
   endtask

   task automatic apbWrite(input cpuPkg::paddrT addr, input cpuPkg::wordT data,
                           output int waits, output logic err);
      cpuPkg::wordT ignored;
      apbTransfer(1'b1, addr, data, ignored, waits, err);
   endtask

   task automatic apbRead(input cpuPkg::paddrT addr, output cpuPkg::wordT data,
                          output int waits, output logic err);
      apbTransfer(1'b0, addr, '0, data, waits, err);
   endtask

   task automatic writeReg(input cpuPkg::regIdxT idx, input cpuPkg::wordT value);
      int   waits;
      logic err;
      apbWrite(regAddr(idx), value, waits, err);
      checkCount("register write wait states", 0, waits);
      checkFlag("pSlvErr on register write", 1'b0, err);
      model[idx] = value;
   endtask

   task automatic checkReg(input cpuPkg::regIdxT idx);
      cpuPkg::wordT data;
      int           waits;
      logic         err;
      apbRead(regAddr(idx), data, waits, err);
      checkWord($sformatf("R%0d", idx), model[idx], data);
      checkCount("register read wait states", 0, waits);
      checkFlag("pSlvErr on register read", 1'b0, err);
   endtask

   task automatic checkAllRegs();
      for (int i = 0; i < cpuPkg::RegCount; i++) begin
         checkReg(cpuPkg::regIdxT'(i));
      end
   endtask

   // Every instruction write takes three wait states
   task automatic runInstr(input cpuPkg::wordT instrWord, input logic expectErr);
      int   waits;
      logic err;
      apbWrite(cpuPkg::AddrInstr, instrWord, waits, err);
      checkCount("instruction wait states", 3, waits);
      checkFlag("pSlvErr on instruction write", expectErr, err);
   endtask

   task automatic resetAndRegisterTest();
      for (int i = 0; i < cpuPkg::RegCount; i++) begin
         model[i] = '0;
      end
      checkAllRegs();
      for (int i = 0; i < cpuPkg::RegCount; i++) begin
         writeReg(cpuPkg::regIdxT'(i), $random(seed));
      end
      checkAllRegs();
   endtask

   task automatic ldiTest();
      writeReg(4'd2, 32'd2);
      runInstr(encodeInstr(cpuPkg::OpLdi, 4'd5, 4'd2, 19'h21), 1'b0);
      model[5] = 32'h0000_0023;
      checkAllRegs();
   endtask

   // R0 as base reads zero for ldi, but its real value for addi
   task automatic baseAddressTest();
      logic [18:0] c;
      writeReg(4'd0, $random(seed) | 32'h1);
      c = 19'($random(seed));
      c[18] = 1'b1;
      runInstr(encodeInstr(cpuPkg::OpLdi, 4'd7, 4'd0, c), 1'b0);
      model[7] = signExtend(c);
      checkReg(4'd7);
      c = 19'($random(seed));
      runInstr(encodeInstr(cpuPkg::OpAddi, 4'd8, 4'd0, c), 1'b0);
      model[8] = model[0] + signExtend(c);
      checkReg(4'd8);
   endtask

   task automatic logicCase(input cpuPkg::opcodeT op);
      cpuPkg::regIdxT ra;
      cpuPkg::regIdxT rb;
      cpuPkg::wordT   value;
      logic [18:0]    c;
      ra = cpuPkg::regIdxT'($random(seed));
      rb = cpuPkg::regIdxT'($random(seed));
      value = $random(seed);
      c = 19'($random(seed));
      writeReg(rb, value);
      runInstr(encodeInstr(op, ra, rb, c), 1'b0);
      if (op == cpuPkg::OpAndi) begin
         model[ra] = value & signExtend(c);
      end else begin
         model[ra] = value | signExtend(c);
      end
      checkReg(ra);
   endtask

   task automatic logicOpsTest();
      for (int i = 0; i < LogicRounds; i++) begin
         logicCase(cpuPkg::OpAndi);
         logicCase(cpuPkg::OpOri);
      end
      checkAllRegs();
   endtask

   task automatic errorTest();
      cpuPkg::wordT badInstr;
      cpuPkg::wordT data;
      int           waits;
      logic         err;
      badInstr = encodeInstr(5'b11111, 4'd3, 4'd1, 19'h12345);
      runInstr(badInstr, 1'b1);
      apbWrite(8'h20, 32'hdead_beef, waits, err);
      checkCount("unmapped write wait states", 0, waits);
      checkFlag("pSlvErr on unmapped write", 1'b1, err);
      apbRead(8'h84, data, waits, err);
      checkCount("unmapped read wait states", 0, waits);
      checkFlag("pSlvErr on unmapped read", 1'b1, err);
      // Illegal opcode and unmapped write leave the registers alone
      checkAllRegs();
      apbRead(cpuPkg::AddrInstr, data, waits, err);
      checkWord("instruction register", badInstr, data);
      checkCount("instruction read wait states", 0, waits);
      checkFlag("pSlvErr on instruction read", 1'b0, err);
   endtask

   initial begin
      rst = 1'b1;
      pSel = 1'b0;
      pEnable = 1'b0;
      pWrite = 1'b0;
      pAddr = '0;
      pWData = '0;
      repeat (ResetCycles) @(negedge Clock);
      rst = 1'b0;
      resetAndRegisterTest();
      ldiTest();
      baseAddressTest();
      logicOpsTest();
      errorTest();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- ldiDatapath_assertions.sv
// Concurrent assertions on APB handshake and execution sequencing, bound into the top level
module ldiDatapath_assertions (
   input logic Clock,
   input logic rst,
   input logic pSel,
   input logic pEnable,
   input logic pReady,
   input logic aluLoad,
   input logic wbEn,
   input logic illegalOp
);

   timeunit 1ns;
   timeprecision 10ps;

   // Access phase only inside a selected transfer
   enableNeedsSelect: assert property (@(posedge Clock) disable iff (rst)
      pEnable |-> pSel)
      else $error("pEnable high while pSel is low");

   // Write-back follows the ALU load by one cycle
   loadThenWriteBack: assert property (@(posedge Clock) disable iff (rst)
      (aluLoad && !illegalOp) |=> wbEn)
      else $error("wbEn missing one cycle after aluLoad");

   writeBackAfterLoad: assert property (@(posedge Clock) disable iff (rst)
      wbEn |-> $past(aluLoad))
      else $error("wbEn without aluLoad in the cycle before");

   readyInAccess: assert property (@(posedge Clock) disable iff (rst)
      pReady |-> (pSel && pEnable))
      else $error("pReady high outside the access phase");

endmodule

bind ldiDatapath ldiDatapath_assertions checks (
   .Clock(Clock), .rst(rst), .pSel(pSel), .pEnable(pEnable), .pReady(pReady),
   .aluLoad(aluLoad), .wbEn(wbEn), .illegalOp(illegalOp)
);

//--- ldiDatapath.sv
// Top level of the immediate-group execution slice
module ldiDatapath (
   input  logic          Clock,
   input  logic          rst,
   input  logic          pSel,
   input  logic          pEnable,
   input  logic          pWrite,
   input  cpuPkg::paddrT pAddr,
   input  cpuPkg::wordT  pWData,
   output cpuPkg::wordT  pRData,
   output logic          pReady,
   output logic          pSlvErr
);

   cpuPkg::wordT   instr;
   cpuPkg::opcodeT op;
   cpuPkg::regIdxT ra;
   cpuPkg::regIdxT rb;
   cpuPkg::wordT   imm;
   logic           baMode;
   logic           illegalOp;
   cpuPkg::wordT   operand;
   cpuPkg::wordT   result;
   logic           aluLoad;
   logic           wbEn;
   logic           hostWe;
   cpuPkg::regIdxT hostIdx;
   cpuPkg::wordT   hostWData;
   cpuPkg::wordT   hostRData;

   apbControl control (
      .Clock(Clock), .rst(rst), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
      .pAddr(pAddr), .pWData(pWData), .hostRData(hostRData), .illegalOp(illegalOp),
      .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr), .instr(instr),
      .hostWe(hostWe), .hostIdx(hostIdx), .hostWData(hostWData),
      .aluLoad(aluLoad), .wbEn(wbEn)
   );

   // Immediate-side path
   immediateDecoder decoder (
      .instr(instr), .op(op), .ra(ra), .rb(rb), .imm(imm),
      .baMode(baMode), .illegalOp(illegalOp)
   );

   // Register-side path
   registerFile regFile (
      .Clock(Clock), .rst(rst), .rb(rb), .baMode(baMode), .ra(ra), .wbEn(wbEn),
      .result(result), .hostWe(hostWe), .hostIdx(hostIdx), .hostWData(hostWData),
      .operand(operand), .hostRData(hostRData)
   );

   offsetAlu alu (
      .Clock(Clock), .rst(rst), .op(op), .operand(operand), .imm(imm),
      .aluLoad(aluLoad), .result(result)
   );

endmodule

//--- apbControl.sv
// APB slave with instruction register, execution FSM, wait states, errors and read mux
module apbControl (
   input  logic           Clock,
   input  logic           rst,
   input  logic           pSel,
   input  logic           pEnable,
   input  logic           pWrite,
   input  cpuPkg::paddrT  pAddr,
   input  cpuPkg::wordT   pWData,
   input  cpuPkg::wordT   hostRData,
   input  logic           illegalOp,
   output cpuPkg::wordT   pRData,
   output logic           pReady,
   output logic           pSlvErr,
   output cpuPkg::wordT   instr,
   output logic           hostWe,
   output cpuPkg::regIdxT hostIdx,
   output cpuPkg::wordT   hostWData,
   output logic           aluLoad,
   output logic           wbEn
);

   typedef enum logic [1:0] {
      Idle,
      Exec,
      WriteBack,
      Done
   } stateT;

   stateT         state;
   logic          access;
   logic          instrHit;
   logic          regHit;
   logic          unmapped;
   logic          instrWrite;
   cpuPkg::paddrT regOffset;

   // Address decode
   assign access = pSel && pEnable;
   assign instrHit = (pAddr == cpuPkg::AddrInstr);
   assign regHit = (pAddr >= cpuPkg::AddrRegBase) && (pAddr < cpuPkg::AddrRegEnd) &&
                   (pAddr[1:0] == 2'b00);
   assign unmapped = !instrHit && !regHit;
   assign instrWrite = access && pWrite && instrHit;

   assign regOffset = pAddr - cpuPkg::AddrRegBase;
   assign hostIdx = regOffset[cpuPkg::RegIdxWidth+1:2];
   assign hostWData = pWData;

   // Register writes complete in the first access cycle
   assign hostWe = (state == Idle) && access && pWrite && regHit;

   // Instruction register and execution sequence
   always_ff @(posedge Clock) begin
      if (rst) begin
         state <= Idle;
         instr <= '0;
      end else begin
         case (state)
            Idle: begin
               if (instrWrite) begin
                  instr <= pWData;
                  state <= Exec;
               end
            end
            Exec: state <= WriteBack;
            WriteBack: state <= Done;
            default: state <= Idle;
         endcase
      end
   end

   // Decoder output is stable one cycle after the load
   assign aluLoad = (state == Exec) && !illegalOp;
   assign wbEn = (state == WriteBack) && !illegalOp;

   // Zero wait states except for instruction writes
   assign pReady = ((state == Idle) && access && !instrWrite) || (state == Done);
   assign pSlvErr = ((state == Idle) && access && unmapped) ||
                    ((state == Done) && illegalOp);

   // Read data mux
   always_comb begin
      if (instrHit) begin
         pRData = instr;
      end else if (regHit) begin
         pRData = hostRData;
      end else begin
         pRData = '0;
      end
   end

endmodule

//--- offsetAlu.sv
// ALU for the immediate group with its result register
module offsetAlu (
   input  logic           Clock,
   input  logic           rst,
   input  cpuPkg::opcodeT op,
   input  cpuPkg::wordT   operand,
   input  cpuPkg::wordT   imm,
   input  logic           aluLoad,
   output cpuPkg::wordT   result
);

   cpuPkg::wordT aluOut;

   // ldi and addi share the adder
   always_comb begin
      case (op)
         cpuPkg::OpLdi,
         cpuPkg::OpAddi: aluOut = operand + imm;
         cpuPkg::OpAndi: aluOut = operand & imm;
         cpuPkg::OpOri: aluOut = operand | imm;
         default: aluOut = '0;
      endcase
   end

   // Result register, one cycle after aluLoad
   always_ff @(posedge Clock) begin
      if (rst) begin
         result <= '0;
      end else if (aluLoad) begin
         result <= aluOut;
      end
   end

endmodule

//--- registerFile.sv
// Sixteen general registers with operand read, host read/write and write-back ports
module registerFile (
   input  logic           Clock,
   input  logic           rst,
   input  cpuPkg::regIdxT rb,
   input  logic           baMode,
   input  cpuPkg::regIdxT ra,
   input  logic           wbEn,
   input  cpuPkg::wordT   result,
   input  logic           hostWe,
   input  cpuPkg::regIdxT hostIdx,
   input  cpuPkg::wordT   hostWData,
   output cpuPkg::wordT   operand,
   output cpuPkg::wordT   hostRData
);

   cpuPkg::wordT regs [cpuPkg::RegCount];
   logic         rbIsZero;

   // Write-back and host writes never overlap
   always_ff @(posedge Clock) begin
      if (rst) begin
         for (int i = 0; i < cpuPkg::RegCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wbEn) begin
         regs[ra] <= result;
      end else if (hostWe) begin
         regs[hostIdx] <= hostWData;
      end
   end

   assign rbIsZero = (rb == '0);

   // Base-address rule: R0 reads as zero for ldi
   always_comb begin
      if (baMode && rbIsZero) begin
         operand = '0;
      end else begin
         operand = regs[rb];
      end
   end

   // Host read port
   assign hostRData = regs[hostIdx];

endmodule

//--- immediateDecoder.sv
// Instruction field extraction, constant sign extension and opcode checks
module immediateDecoder (
   input  cpuPkg::wordT   instr,
   output cpuPkg::opcodeT op,
   output cpuPkg::regIdxT ra,
   output cpuPkg::regIdxT rb,
   output cpuPkg::wordT   imm,
   output logic           baMode,
   output logic           illegalOp
);

   logic [cpuPkg::ImmWidth-1:0] rawImm;

   assign op = instr[cpuPkg::OpMsb:cpuPkg::OpLsb];
   assign ra = instr[cpuPkg::RaMsb:cpuPkg::RaLsb];
   assign rb = instr[cpuPkg::RbMsb:cpuPkg::RbLsb];

   // 19-bit constant, sign bit replicated upward
   assign rawImm = instr[cpuPkg::ImmWidth-1:0];
   assign imm = {{(cpuPkg::DataWidth - cpuPkg::ImmWidth){rawImm[cpuPkg::ImmWidth-1]}}, rawImm};

   // Only ldi treats Rb as a base address
   assign baMode = (op == cpuPkg::OpLdi);

   always_comb begin
      case (op)
         cpuPkg::OpLdi,
         cpuPkg::OpAddi,
         cpuPkg::OpAndi,
         cpuPkg::OpOri: illegalOp = 1'b0;
         default: illegalOp = 1'b1;
      endcase
   end

endmodule

//--- cpuPkg.sv
// Word, index and opcode types, instruction field positions, opcodes, APB address map
package cpuPkg;

   // Data and register sizes
   localparam int DataWidth = 32;
   localparam int RegCount = 16;
   localparam int RegIdxWidth = 4;
   localparam int OpWidth = 5;
   localparam int AddrWidth = 8;

   typedef logic [DataWidth-1:0] wordT;
   typedef logic [RegIdxWidth-1:0] regIdxT;
   typedef logic [OpWidth-1:0] opcodeT;
   typedef logic [AddrWidth-1:0] paddrT;

   // Instruction word layout
   localparam int OpMsb = 31;
   localparam int OpLsb = 27;
   localparam int RaMsb = 26;
   localparam int RaLsb = 23;
   localparam int RbMsb = 22;
   localparam int RbLsb = 19;
   localparam int ImmWidth = 19;

   // Immediate-group opcodes
   localparam opcodeT OpLdi = 5'b00100;
   localparam opcodeT OpAddi = 5'b00101;
   localparam opcodeT OpAndi = 5'b00110;
   localparam opcodeT OpOri = 5'b00111;

   // APB address map, register n at AddrRegBase + 4*n
   localparam paddrT AddrInstr = 8'h00;
   localparam paddrT AddrRegBase = 8'h40;
   localparam paddrT AddrRegEnd = 8'h80;

endpackage
